/* project.f */
+incdir+include
rtl/sqrt_pkg.sv
rtl/sqrt_engine.sv
rtl/sqrt_req_fifo.sv
rtl/sqrt_dispatch.sv
rtl/sqrt_result_order.sv
rtl/sqrt_unit_top.sv
bench/tb_sqrt_unit.sv

/* Makefile */
# Verilator build and run for the square-root unit testbench

VERILATOR ?= verilator
TOP       ?= tb_sqrt_unit
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Everything OK
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* include/sqrt_ref_model.svh */
`ifndef SQRT_REF_MODEL_SVH
`define SQRT_REF_MODEL_SVH

`include "sqrt_params.svh"

// Floor square root by trial squaring, independent of the engine's recurrence
function automatic sqrt_pkg::sqrt_word_t sqrt_ref_model(
    input logic                 mode,
    input sqrt_pkg::sqrt_word_t radicand
);
    logic [63:0]          value;
    logic [63:0]          root;
    logic [63:0]          trial;
    sqrt_pkg::sqrt_word_t res;

    root = '0;
    if (mode) begin
        // Q16.16 root is the integer root of the radicand times 2^16
        value = 64'({radicand.fixed.int_part, radicand.fixed.frac_part});
        value = value << `SQRT_FRAC_WIDTH;
    end else begin
        value = 64'(radicand.raw);
    end

    for (int b = 31; b >= 0; b--) begin
        trial = root | (64'd1 << b);
        if (trial * trial <= value) begin
            root = trial;
        end
    end

    res.raw = root[`SQRT_WIDTH-1:0];
    return res;
endfunction

`endif

/* bench/tb_sqrt_unit.sv */
`timescale 1ns/1ps
`include "sqrt_params.svh"

module tb_sqrt_unit;
    import sqrt_pkg::*;

    `include "sqrt_ref_model.svh"

    localparam int wait_limit = 1000;   // Cycles any single wait may take
    localparam int hold_cycles = 200;

    logic       clk;
    logic       rst;
    logic       in_valid;
    logic       in_mode;
    sqrt_word_t in_data;
    logic       in_credit;
    logic       out_credit;
    logic       out_valid;
    logic       out_mode;
    sqrt_word_t out_data;

    integer     seed = 49;
    int         prod_credits;
    int         out_model;      // Unit's output credit count, tracked from outside
    logic       credit_seen;
    logic       hold_credits;
    int         cycle;
    int         error_count;
    int         return_due [$]; // Cycles at which consumer frees a slot
    logic       exp_mode [$];
    sqrt_word_t exp_data [$];

    logic [31:0] int_edges [7] = '{32'd0, 32'd1, 32'd4, 32'd144, 32'd65536,
                                   32'hFFFE0001, 32'hFFFFFFFF};
    logic [31:0] fix_edges [6] = '{32'd0, 32'd1, 32'h00004000, 32'h00010000,
                                   32'h00020000, 32'hFFFFFFFF};

    sqrt_unit_top UUT (.*);

    always #2 clk = ~clk;

    task automatic stop_with_failure();
        error_count++;
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, want);
            stop_with_failure();
        end
    endtask

    task automatic send_req(input logic mode, input sqrt_word_t data);
        int waited;
        waited = 0;
        while (prod_credits == 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > wait_limit) begin
                $display("Producer waited too long for an input credit");
                stop_with_failure();
            end
        end
        in_valid = 1'b1;
        in_mode = mode;
        in_data = data;
        prod_credits--;
        exp_mode.push_back(mode);
        exp_data.push_back(data);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_data.size() != 0 || return_due.size() != 0 ||
               prod_credits != `SQRT_IN_DEPTH) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > wait_limit) begin
                $display("Unit did not drain and return all credits in time");
                stop_with_failure();
            end
        end
        repeat (3) begin
            @(posedge clk);
            #1;
        end
        check_value("output credits after drain", 32'(UUT.u_order.credits),
                    `SQRT_OUT_CREDITS);
    endtask

    // Credit bookkeeping on both sides
    always @(negedge clk) begin
        if (rst) begin
            out_model = `SQRT_OUT_CREDITS;
            credit_seen = 1'b0;
        end else begin
            if (in_credit) begin
                prod_credits++;
                if (prod_credits > `SQRT_IN_DEPTH) begin
                    $display("More input credits came back than were spent");
                    stop_with_failure();
                end
            end
            if (out_valid) begin
                if (out_model == 0) begin
                    $display("Result sent while the unit held no output credit");
                    stop_with_failure();
                end
                out_model--;
                return_due.push_back(cycle + int'($unsigned($random(seed)) % 6));
            end
            out_model += int'(credit_seen);  // Unit counts it on the next edge
            credit_seen = out_credit;
        end
    end

    always @(negedge clk) begin
        sqrt_word_t want;
        if (!rst && out_valid) begin
            if (exp_data.size() == 0) begin
                $display("Result arrived with no request outstanding");
                stop_with_failure();
            end
            want = sqrt_ref_model(exp_mode[0], exp_data[0]);
            check_value("out_mode", 32'(out_mode), 32'(exp_mode[0]));
            check_value("out_data", out_data.raw, want.raw);
            void'(exp_mode.pop_front());
            void'(exp_data.pop_front());
        end
    end

    // Consumer slot release
    initial begin
        out_credit = 1'b0;
        cycle = 0;
        forever begin
            @(posedge clk);
            #1;
            cycle++;
            out_credit = 1'b0;
            if (!hold_credits && return_due.size() != 0 && return_due[0] <= cycle) begin
                void'(return_due.pop_front());
                out_credit = 1'b1;
            end
        end
    end

    initial begin
        sqrt_word_t w;
        clk = 1'b0;
        rst = 1'b1;
        in_valid = 1'b0;
        in_mode = 1'b0;
        in_data = '0;
        hold_credits = 1'b0;
        error_count = 0;
        prod_credits = `SQRT_IN_DEPTH;
        out_model = `SQRT_OUT_CREDITS;
        credit_seen = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        repeat (8) begin
            check_value("in_credit while idle", 32'(in_credit), 32'd0);
            check_value("out_valid while idle", 32'(out_valid), 32'd0);
            @(posedge clk);
            #1;
        end

        for (int i = 0; i < 7; i++) begin
            w.raw = int_edges[i];
            send_req(1'b0, w);
        end
        for (int i = 0; i < 12; i++) begin
            w.raw = $random(seed);
            send_req(1'b0, w);
        end
        wait_drain();

        for (int i = 0; i < 6; i++) begin
            w.raw = fix_edges[i];
            send_req(1'b1, w);
        end
        for (int i = 0; i < 12; i++) begin
            w.raw = $random(seed);
            if (i < 6) begin
                w.fixed.int_part = '0;  // Pure fractions
            end
            send_req(1'b1, w);
        end
        wait_drain();

        // Fixed first so the integers behind it finish earlier
        for (int i = 0; i < 18; i++) begin
            w.raw = $random(seed);
            send_req((i % 3) == 0, w);
        end
        wait_drain();

        @(negedge clk);
        hold_credits = 1'b1;
        @(posedge clk);
        #1;
        fork
            begin
                for (int i = 0; i < 12; i++) begin
                    w.raw = $random(seed);
                    send_req((i % 2) == 1, w);
                end
            end
            begin
                repeat (hold_cycles) @(negedge clk);
                hold_credits = 1'b0;
            end
        join
        wait_drain();

        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* rtl/sqrt_unit_top.sv */
`timescale 1ns/1ps
`include "sqrt_params.svh"

module sqrt_unit_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  logic                 in_mode,
    input  sqrt_pkg::sqrt_word_t in_data,
    output logic                 in_credit,
    input  logic                 out_credit,
    output logic                 out_valid,
    output logic                 out_mode,
    output sqrt_pkg::sqrt_word_t out_data
);
    import sqrt_pkg::*;

    logic                    req_valid;
    logic                    req_mode;
    sqrt_word_t              req_data;
    logic                    req_pop;
    logic [`SQRT_LANES-1:0]  lane_go;
    logic                    go_mode;
    sqrt_word_t              go_data;
    logic                    issue_valid;
    logic [`SQRT_LANE_W-1:0] issue_lane;
    logic                    order_full;
    logic [`SQRT_LANES-1:0]  lane_idle;
    logic [`SQRT_LANES-1:0]  lane_valid;
    logic [`SQRT_LANES-1:0]  lane_mode;
    logic [`SQRT_LANES-1:0]  lane_take;
    sqrt_word_t              lane_result [`SQRT_LANES];

    sqrt_req_fifo u_fifo (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .in_mode(in_mode),
        .in_data(in_data),
        .req_pop(req_pop),
        .req_valid(req_valid),
        .req_mode(req_mode),
        .req_data(req_data),
        .in_credit(in_credit)
    );

    sqrt_dispatch u_dispatch (
        .clk(clk),
        .rst(rst),
        .req_valid(req_valid),
        .req_mode(req_mode),
        .req_data(req_data),
        .lane_idle(lane_idle),
        .order_full(order_full),
        .req_pop(req_pop),
        .go(lane_go),
        .go_mode(go_mode),
        .go_data(go_data),
        .issue_valid(issue_valid),
        .issue_lane(issue_lane)
    );

    for (genvar g = 0; g < `SQRT_LANES; g++) begin : g_lane
        sqrt_engine u_engine (
            .clk(clk),
            .rst(rst),
            .go(lane_go[g]),
            .mode(go_mode),
            .radicand(go_data),
            .take(lane_take[g]),
            .idle(lane_idle[g]),
            .result_valid(lane_valid[g]),
            .result_mode(lane_mode[g]),
            .result(lane_result[g])
        );
    end

    sqrt_result_order u_order (
        .clk(clk),
        .rst(rst),
        .issue_valid(issue_valid),
        .issue_lane(issue_lane),
        .result_valid(lane_valid),
        .result_mode(lane_mode),
        .result(lane_result),
        .out_credit(out_credit),
        .order_full(order_full),
        .take(lane_take),
        .out_valid(out_valid),
        .out_mode(out_mode),
        .out_data(out_data)
    );

endmodule

/* rtl/sqrt_result_order.sv */
`timescale 1ns/1ps
`include "sqrt_params.svh"

module sqrt_result_order (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     issue_valid,
    input  logic [`SQRT_LANE_W-1:0]  issue_lane,
    input  logic [`SQRT_LANES-1:0]   result_valid,
    input  logic [`SQRT_LANES-1:0]   result_mode,
    input  sqrt_pkg::sqrt_word_t     result [`SQRT_LANES],
    input  logic                     out_credit,
    output logic                     order_full,
    output logic [`SQRT_LANES-1:0]   take,
    output logic                     out_valid,
    output logic                     out_mode,
    output sqrt_pkg::sqrt_word_t     out_data
);
    localparam int depth = `SQRT_IN_DEPTH;
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);
    localparam int cred_w = $clog2(`SQRT_OUT_CREDITS + 1);

    logic [`SQRT_LANE_W-1:0] lane_q [depth];  // Lanes in issue order
    logic [ptr_w-1:0]        wr_ptr;
    logic [ptr_w-1:0]        rd_ptr;
    logic [cnt_w-1:0]        count;
    logic [cred_w-1:0]       credits;
    logic [`SQRT_LANE_W-1:0] head_lane;
    logic                    send;

    assign head_lane = lane_q[rd_ptr];
    assign send = (count != '0) && result_valid[head_lane] && (credits != '0);

    // Counts the issue already on its way in
    assign order_full = (count == cnt_w'(depth)) ||
                        (issue_valid && (count == cnt_w'(depth - 1)));

    always_comb begin
        take = '0;
        if (send) begin
            take[head_lane] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            lane_q[wr_ptr] <= issue_lane;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            credits <= cred_w'(`SQRT_OUT_CREDITS);
            out_valid <= 1'b0;
        end else begin
            out_valid <= send;
            if (issue_valid) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({issue_valid, send})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({send, out_credit})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            out_mode <= result_mode[head_lane];
            out_data <= result[head_lane];
        end
    end

endmodule

/* rtl/sqrt_dispatch.sv */
`timescale 1ns/1ps
`include "sqrt_params.svh"

module sqrt_dispatch (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid,
    input  logic                     req_mode,
    input  sqrt_pkg::sqrt_word_t     req_data,
    input  logic [`SQRT_LANES-1:0]   lane_idle,
    input  logic                     order_full,
    output logic                     req_pop,
    output logic [`SQRT_LANES-1:0]   go,
    output logic                     go_mode,
    output sqrt_pkg::sqrt_word_t     go_data,
    output logic                     issue_valid,
    output logic [`SQRT_LANE_W-1:0]  issue_lane
);
    logic [`SQRT_LANES-1:0]  avail;
    logic [`SQRT_LANE_W-1:0] last;
    logic [`SQRT_LANE_W-1:0] pick;
    logic                    found;
    logic                    issue;
    int                      cand;

    // A lane granted last cycle has not seen its go yet
    assign avail = lane_idle & ~go;

    // Search starts just after the previous grant
    always_comb begin
        pick = last;
        found = 1'b0;
        cand = 0;
        for (int i = 1; i <= `SQRT_LANES; i++) begin
            cand = (int'(last) + i) % `SQRT_LANES;
            if (!found && avail[cand]) begin
                found = 1'b1;
                pick = cand[`SQRT_LANE_W-1:0];
            end
        end
    end

    assign issue = req_valid && found && !order_full;
    assign req_pop = issue;

    always_ff @(posedge clk) begin
        if (rst) begin
            go <= '0;
            issue_valid <= 1'b0;
            last <= '1;  // First grant lands on lane 0
        end else begin
            go <= '0;
            issue_valid <= issue;
            if (issue) begin
                go[pick] <= 1'b1;
                last <= pick;
            end
        end
    end

    // Operand is broadcast, only the chosen lane starts
    always_ff @(posedge clk) begin
        if (issue) begin
            go_mode <= req_mode;
            go_data <= req_data;
            issue_lane <= pick;
        end
    end

endmodule

/* rtl/sqrt_req_fifo.sv */
`timescale 1ns/1ps
`include "sqrt_params.svh"

module sqrt_req_fifo (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  logic                 in_mode,
    input  sqrt_pkg::sqrt_word_t in_data,
    input  logic                 req_pop,
    output logic                 req_valid,
    output logic                 req_mode,
    output sqrt_pkg::sqrt_word_t req_data,
    output logic                 in_credit
);
    import sqrt_pkg::*;

    localparam int depth = `SQRT_IN_DEPTH;
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    logic       mode_mem [depth];
    sqrt_word_t data_mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    assign req_valid = (count != '0);
    assign req_mode = mode_mem[rd_ptr];
    assign req_data = data_mem[rd_ptr];

    // Producer credits guarantee a free slot
    always_ff @(posedge clk) begin
        if (in_valid) begin
            mode_mem[wr_ptr] <= in_mode;
            data_mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            in_credit <= 1'b0;
        end else begin
            in_credit <= req_pop;  // One credit back per entry leaving
            if (in_valid) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (req_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({in_valid, req_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* rtl/sqrt_engine.sv */
`timescale 1ns/1ps
`include "sqrt_params.svh"

module sqrt_engine (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 go,
    input  logic                 mode,
    input  sqrt_pkg::sqrt_word_t radicand,
    input  logic                 take,
    output logic                 idle,
    output logic                 result_valid,
    output logic                 result_mode,
    output sqrt_pkg::sqrt_word_t result
);
    localparam int ext_w = `SQRT_WIDTH + `SQRT_FRAC_WIDTH;  // Radicand plus fraction pad
    localparam int root_w = ext_w / 2;
    localparam int acc_w = root_w + 2;
    localparam int int_iters = `SQRT_WIDTH / 2;
    localparam int fix_iters = ext_w / 2;
    localparam int idx_w = $clog2(fix_iters + 1);

    logic [idx_w-1:0]  idx;
    logic [idx_w-1:0]  last_idx;
    logic              running;
    logic              run_mode;
    logic              start;
    logic              finished;
    logic [ext_w-1:0]  x;
    logic [ext_w-1:0]  x_next;
    logic [root_w-1:0] root;
    logic [root_w-1:0] root_next;
    logic [acc_w-1:0]  acc;
    logic [acc_w-1:0]  acc_next;
    logic [acc_w:0]    diff;

    assign idle = !running && !result_valid;
    assign start = go && idle;  // Busy lane ignores go
    assign last_idx = run_mode ? idx_w'(fix_iters - 1) : idx_w'(int_iters - 1);
    assign finished = running && (idx == last_idx);

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            result_valid <= 1'b0;
            idx <= '0;
        end else begin
            if (start) begin
                running <= 1'b1;
            end else if (finished) begin
                running <= 1'b0;
            end
            if (finished) begin
                result_valid <= 1'b1;
            end else if (take) begin
                result_valid <= 1'b0;
            end
            idx <= running ? idx + 1'b1 : '0;
        end
    end

    // One root bit per step, extra top bit keeps the sign honest
    always_comb begin
        diff = {1'b0, acc} - {1'b0, root, 2'b01};
        if (diff[acc_w]) begin
            {acc_next, x_next} = {acc[root_w-1:0], x, 2'b00};
            root_next = {root[root_w-2:0], 1'b0};
        end else begin
            {acc_next, x_next} = {diff[root_w-1:0], x, 2'b00};
            root_next = {root[root_w-2:0], 1'b1};
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            run_mode <= mode;
            root <= '0;
            // Integer mode stops before reaching the zero pad
            {acc, x} <= {{root_w{1'b0}}, radicand.raw, {`SQRT_FRAC_WIDTH{1'b0}}, 2'b00};
        end else if (running) begin
            acc <= acc_next;
            x <= x_next;
            root <= root_next;
        end
    end

    always_ff @(posedge clk) begin
        if (finished) begin
            result.raw <= {{(`SQRT_WIDTH - root_w){1'b0}}, root_next};
            result_mode <= run_mode;
        end
    end

endmodule

/* rtl/sqrt_pkg.sv */
`include "sqrt_params.svh"

package sqrt_pkg;

    // One operand word, seen either raw or as a Q16.16 split
    typedef union packed {
        logic [`SQRT_WIDTH-1:0] raw;
        struct packed {
            logic [`SQRT_WIDTH-`SQRT_FRAC_WIDTH-1:0] int_part;
            logic [`SQRT_FRAC_WIDTH-1:0]             frac_part;
        } fixed;
    } sqrt_word_t;

endpackage

/* include/sqrt_params.svh */
`ifndef SQRT_PARAMS_SVH
`define SQRT_PARAMS_SVH

// Operand and result word
`define SQRT_WIDTH 32
`define SQRT_FRAC_WIDTH 16      // Q16.16 in fixed mode

`define SQRT_LANES 2            // Engines working in parallel
`define SQRT_LANE_W ((`SQRT_LANES > 1) ? $clog2(`SQRT_LANES) : 1)

`define SQRT_IN_DEPTH 4         // Also the producer's starting credits
`define SQRT_OUT_CREDITS 2

`endif
